/* src/exec_isa_pkg.sv */
// ISA constants for the execute stage
// ALU opcode enum shared by the pipeline and the top level

package exec_isa_pkg;

    // data and PC width
    localparam int XLEN = 32;

    // register index width for the destination field
    localparam int RD_W = 5;

    // only the low bits of rs2 count as a shift amount
    localparam int SHAMT_W = 5;

    // link value offset for JAL
    localparam logic [XLEN-1:0] PC_INC = XLEN'(4);

    // ALU opcodes
    // arithmetic and logic ops write a per-lane result,
    // branches and EBREAK/ECALL write zero,
    // JAL writes pc plus 4 on every active lane
    typedef enum logic [3:0] {
        OP_ADD          = 4'd0,
        OP_SUB          = 4'd1,
        OP_AND          = 4'd2,
        OP_OR           = 4'd3,
        OP_XOR          = 4'd4,
        OP_SLL          = 4'd5,
        OP_SRL          = 4'd6,
        OP_SLT          = 4'd7,
        OP_BEQ          = 4'd8,
        OP_BNE          = 4'd9,
        OP_JAL          = 4'd10,
        OP_EBREAK_ECALL = 4'd11
    } alu_op_t;

endpackage

/* src/exec_itr_pkg.sv */
// JAL-overload state encoding for hardware interrupt return

package exec_itr_pkg;

    // state of the JAL-overload tracker
    // OVL_OFF       overloading not requested, hit bits held clear
    // OVL_ARMED     waiting for the first JAL of every warp
    // OVL_COMPLETE  every warp has committed its overloaded JAL
    typedef enum logic [1:0] {
        OVL_OFF      = 2'd0,
        OVL_ARMED    = 2'd1,
        OVL_COMPLETE = 2'd2
    } ovl_state_t;

endpackage

/* src/alu_unit.sv */
// two-stage SIMT ALU and branch pipeline with valid/ready dispatch and commit
// also holds the simulation-stop detector for EBREAK/ECALL on warp 0
`timescale 1ns/100ps

module alu_unit import exec_isa_pkg::*; #(
    parameter int WARP_CNT   = 4,
    parameter int THREAD_CNT = 4,
    parameter int WID_W      = (WARP_CNT > 1) ? $clog2(WARP_CNT) : 1
) (
    input  logic                       clk,
    input  logic                       reset,

    // dispatch side
    input  logic                       dispatch_valid,
    output logic                       dispatch_ready,
    input  logic [WID_W-1:0]           dispatch_wid,
    input  logic [THREAD_CNT-1:0]      dispatch_tmask,
    input  logic [XLEN-1:0]            dispatch_pc,
    input  alu_op_t                    dispatch_op,
    input  logic [RD_W-1:0]            dispatch_rd,
    input  logic                       dispatch_wb,
    input  logic [THREAD_CNT*XLEN-1:0] dispatch_rs1_data,
    input  logic [THREAD_CNT*XLEN-1:0] dispatch_rs2_data,
    input  logic [XLEN-1:0]            dispatch_imm,

    // commit side
    output logic                       commit_valid,
    input  logic                       commit_ready,
    output logic [WID_W-1:0]           commit_wid,
    output logic [THREAD_CNT-1:0]      commit_tmask,
    output logic [XLEN-1:0]            commit_pc,
    output logic [RD_W-1:0]            commit_rd,
    output logic                       commit_wb,
    output logic [THREAD_CNT*XLEN-1:0] commit_data,
    output logic                       commit_is_jal,

    // branch control
    output logic                       branch_valid,
    output logic [WID_W-1:0]           branch_wid,
    output logic                       branch_taken,
    output logic [XLEN-1:0]            branch_dest,

    output logic                       sim_ebreak
);

    // stage 1 holds the operands and the opcode
    logic                       s1_valid;
    logic [WID_W-1:0]           s1_wid;
    logic [THREAD_CNT-1:0]      s1_tmask;
    logic [XLEN-1:0]            s1_pc;
    alu_op_t                    s1_op;
    logic [RD_W-1:0]            s1_rd;
    logic                       s1_wb;
    logic [THREAD_CNT*XLEN-1:0] s1_rs1;
    logic [THREAD_CNT*XLEN-1:0] s1_rs2;
    logic [XLEN-1:0]            s1_imm;

    // stage 2 holds the lane results and the branch decision
    logic                       s2_valid;
    logic [WID_W-1:0]           s2_wid;
    logic [THREAD_CNT-1:0]      s2_tmask;
    logic [XLEN-1:0]            s2_pc;
    logic [RD_W-1:0]            s2_rd;
    logic                       s2_wb;
    logic [THREAD_CNT*XLEN-1:0] s2_data;
    logic                       s2_is_jal;
    logic                       s2_is_br;
    logic                       s2_taken;
    logic [XLEN-1:0]            s2_dest;

    logic                       s1_ready;
    logic                       s2_ready;
    logic                       dispatch_fire;
    logic                       s1_move;
    logic                       commit_fire;
    logic [THREAD_CNT*XLEN-1:0] lane_data;
    logic                       lane0_eq;
    logic                       br_taken;
    logic                       is_br;

    function automatic logic [XLEN-1:0] lane_result(
        input alu_op_t         op,
        input logic [XLEN-1:0] a,
        input logic [XLEN-1:0] b,
        input logic [XLEN-1:0] pc
    );
        logic [XLEN-1:0] res;
        case (op)
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            OP_SLL:  res = a << b[SHAMT_W-1:0];
            OP_SRL:  res = a >> b[SHAMT_W-1:0];
            OP_SLT:  res = {{(XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
            OP_JAL:  res = pc + PC_INC;
            // branches and EBREAK/ECALL write nothing useful
            default: res = '0;
        endcase
        return res;
    endfunction

    // a stage can take new data when it is empty or its content leaves this cycle
    assign s2_ready       = !s2_valid || commit_ready;
    assign s1_ready       = !s1_valid || s2_ready;
    assign dispatch_ready = s1_ready;

    assign dispatch_fire = dispatch_valid && dispatch_ready;
    assign s1_move       = s1_valid && s2_ready;
    assign commit_fire   = s2_valid && commit_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            if (s1_ready) begin
                s1_valid <= dispatch_valid;
            end
            if (s2_ready) begin
                s2_valid <= s1_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch_fire) begin
            s1_wid   <= dispatch_wid;
            s1_tmask <= dispatch_tmask;
            s1_pc    <= dispatch_pc;
            s1_op    <= dispatch_op;
            s1_rd    <= dispatch_rd;
            s1_wb    <= dispatch_wb;
            s1_rs1   <= dispatch_rs1_data;
            s1_rs2   <= dispatch_rs2_data;
            s1_imm   <= dispatch_imm;
        end
    end

    // per-lane arithmetic, inactive lanes stay zero
    always_comb begin
        for (int i = 0; i < THREAD_CNT; i++) begin
            if (s1_tmask[i]) begin
                lane_data[i*XLEN +: XLEN] = lane_result(s1_op,
                                                        s1_rs1[i*XLEN +: XLEN],
                                                        s1_rs2[i*XLEN +: XLEN],
                                                        s1_pc);
            end else begin
                lane_data[i*XLEN +: XLEN] = '0;
            end
        end
    end

    // branches are uniform, so lane 0 decides for the whole warp
    assign lane0_eq = (s1_rs1[XLEN-1:0] == s1_rs2[XLEN-1:0]);
    assign is_br    = (s1_op == OP_BEQ) || (s1_op == OP_BNE) || (s1_op == OP_JAL);

    always_comb begin
        case (s1_op)
            OP_BEQ:  br_taken = lane0_eq;
            OP_BNE:  br_taken = !lane0_eq;
            OP_JAL:  br_taken = 1'b1;
            default: br_taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (s1_move) begin
            s2_wid    <= s1_wid;
            s2_tmask  <= s1_tmask;
            s2_pc     <= s1_pc;
            s2_rd     <= s1_rd;
            s2_wb     <= s1_wb;
            s2_data   <= lane_data;
            s2_is_jal <= (s1_op == OP_JAL);
            s2_is_br  <= is_br;
            s2_taken  <= br_taken;
            s2_dest   <= s1_pc + s1_imm;
        end
    end

    assign commit_valid  = s2_valid;
    assign commit_wid    = s2_wid;
    assign commit_tmask  = s2_tmask;
    assign commit_pc     = s2_pc;
    assign commit_rd     = s2_rd;
    assign commit_wb     = s2_wb;
    assign commit_data   = s2_data;
    assign commit_is_jal = s2_is_jal;

    // branch info is reported once, when the commit is taken
    assign branch_valid = commit_fire && s2_is_br;
    assign branch_wid   = s2_wid;
    assign branch_taken = s2_taken;
    assign branch_dest  = s2_dest;

    // test programs end with EBREAK or ECALL on warp 0
    assign sim_ebreak = dispatch_fire
                     && (dispatch_wid == '0)
                     && (dispatch_op == OP_EBREAK_ECALL);

endmodule

/* src/jal_overload.sv */
// JAL-overload block for hardware interrupt return
// per-warp first-JAL tracker, link-data rewrite and return-address save outputs
`timescale 1ns/100ps

module jal_overload import exec_isa_pkg::*; import exec_itr_pkg::*; #(
    parameter int WARP_CNT   = 4,
    parameter int THREAD_CNT = 4,
    parameter int WID_W      = (WARP_CNT > 1) ? $clog2(WARP_CNT) : 1
) (
    input  logic                       clk,
    input  logic                       reset,

    // overload control
    input  logic                       overload_jal,
    input  logic [XLEN-1:0]            ret_handler_addr,

    // raw commit from the ALU
    input  logic                       in_valid,
    output logic                       in_ready_out,
    input  logic [WID_W-1:0]           in_wid,
    input  logic                       in_is_jal,
    input  logic [THREAD_CNT-1:0]      in_tmask,
    input  logic [THREAD_CNT*XLEN-1:0] in_data,

    // commit towards the register file
    output logic                       out_valid,
    output logic [THREAD_CNT*XLEN-1:0] out_data,
    input  logic                       out_ready,

    // original link value for the interrupt controller to save
    output logic                       ret_save_valid,
    output logic [WID_W-1:0]           ret_save_wid,
    output logic [XLEN-1:0]            ret_save_pc,
    output ovl_state_t                 ovl_state,
    output logic                       all_hit
);

    ovl_state_t          state;
    ovl_state_t          state_next;
    logic [WARP_CNT-1:0] hits;
    logic [WARP_CNT-1:0] hits_next;
    logic [WARP_CNT-1:0] wid_onehot;
    logic                first_jal;

    assign wid_onehot = {{(WARP_CNT-1){1'b0}}, 1'b1} << in_wid;

    // first JAL of a warp while armed, held steady while the commit waits
    assign first_jal = (state == OVL_ARMED)
                    && in_valid
                    && in_is_jal
                    && !hits[in_wid];

    // the save only counts once the commit is actually taken
    assign ret_save_valid = first_jal && out_ready;
    assign ret_save_wid   = in_wid;
    assign ret_save_pc    = in_data[XLEN-1:0];

    always_comb begin
        state_next = state;
        hits_next  = hits;
        case (state)
            OVL_OFF: begin
                if (overload_jal) begin
                    state_next = OVL_ARMED;
                    hits_next  = '0;
                end
            end
            OVL_ARMED: begin
                if (ret_save_valid) begin
                    hits_next = hits | wid_onehot;
                end
                if (&hits_next) begin
                    state_next = OVL_COMPLETE;
                end
            end
            default: begin
                state_next = state;
            end
        endcase
        // dropping the request ends overloading from any state
        if (!overload_jal) begin
            state_next = OVL_OFF;
            hits_next  = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= OVL_OFF;
            hits  <= '0;
        end else begin
            state <= state_next;
            hits  <= hits_next;
        end
    end

    // swap the link value for the handler address on the active lanes
    always_comb begin
        out_data = in_data;
        for (int i = 0; i < THREAD_CNT; i++) begin
            if (first_jal && in_tmask[i]) begin
                out_data[i*XLEN +: XLEN] = ret_handler_addr;
            end
        end
    end

    assign out_valid    = in_valid;
    assign in_ready_out = out_ready;

    assign ovl_state = state;
    assign all_hit   = &hits;

endmodule

/* src/execute_stage.sv */
// top level of the SIMT execute stage
// ALU pipeline followed by the JAL-overload commit block
`timescale 1ns/100ps

module execute_stage import exec_isa_pkg::*; import exec_itr_pkg::*; #(
    parameter int WARP_CNT   = 4,
    parameter int THREAD_CNT = 4,
    parameter int WID_W      = (WARP_CNT > 1) ? $clog2(WARP_CNT) : 1
) (
    input  logic                       clk,
    input  logic                       reset,

    input  logic                       dispatch_valid,
    output logic                       dispatch_ready,
    input  logic [WID_W-1:0]           dispatch_wid,
    input  logic [THREAD_CNT-1:0]      dispatch_tmask,
    input  logic [XLEN-1:0]            dispatch_pc,
    input  alu_op_t                    dispatch_op,
    input  logic [RD_W-1:0]            dispatch_rd,
    input  logic                       dispatch_wb,
    input  logic [THREAD_CNT*XLEN-1:0] dispatch_rs1_data,
    input  logic [THREAD_CNT*XLEN-1:0] dispatch_rs2_data,
    input  logic [XLEN-1:0]            dispatch_imm,

    output logic                       commit_valid,
    input  logic                       commit_ready,
    output logic [WID_W-1:0]           commit_wid,
    output logic [THREAD_CNT-1:0]      commit_tmask,
    output logic [XLEN-1:0]            commit_pc,
    output logic [RD_W-1:0]            commit_rd,
    output logic                       commit_wb,
    output logic [THREAD_CNT*XLEN-1:0] commit_data,

    output logic                       branch_valid,
    output logic [WID_W-1:0]           branch_wid,
    output logic                       branch_taken,
    output logic [XLEN-1:0]            branch_dest,

    input  logic                       overload_jal,
    input  logic [XLEN-1:0]            ret_handler_addr,
    output logic                       ret_save_valid,
    output logic [WID_W-1:0]           ret_save_wid,
    output logic [XLEN-1:0]            ret_save_pc,
    output ovl_state_t                 ovl_state,
    output logic                       all_hit,

    output logic                       sim_ebreak
);

    // raw commit between the ALU and the overload block
    logic                       alu_commit_valid;
    logic                       alu_commit_ready;
    logic                       alu_commit_is_jal;
    logic [THREAD_CNT*XLEN-1:0] alu_commit_data;

    alu_unit #(
        .WARP_CNT   (WARP_CNT),
        .THREAD_CNT (THREAD_CNT),
        .WID_W      (WID_W)
    ) i_alu (
        .clk               (clk),
        .reset             (reset),
        .dispatch_valid    (dispatch_valid),
        .dispatch_ready    (dispatch_ready),
        .dispatch_wid      (dispatch_wid),
        .dispatch_tmask    (dispatch_tmask),
        .dispatch_pc       (dispatch_pc),
        .dispatch_op       (dispatch_op),
        .dispatch_rd       (dispatch_rd),
        .dispatch_wb       (dispatch_wb),
        .dispatch_rs1_data (dispatch_rs1_data),
        .dispatch_rs2_data (dispatch_rs2_data),
        .dispatch_imm      (dispatch_imm),
        .commit_valid      (alu_commit_valid),
        .commit_ready      (alu_commit_ready),
        .commit_wid        (commit_wid),
        .commit_tmask      (commit_tmask),
        .commit_pc         (commit_pc),
        .commit_rd         (commit_rd),
        .commit_wb         (commit_wb),
        .commit_data       (alu_commit_data),
        .commit_is_jal     (alu_commit_is_jal),
        .branch_valid      (branch_valid),
        .branch_wid        (branch_wid),
        .branch_taken      (branch_taken),
        .branch_dest       (branch_dest),
        .sim_ebreak        (sim_ebreak)
    );

    // wid, tmask, pc, rd and wb go straight out, only the data is rewritten
    jal_overload #(
        .WARP_CNT   (WARP_CNT),
        .THREAD_CNT (THREAD_CNT),
        .WID_W      (WID_W)
    ) i_jal_ovl (
        .clk              (clk),
        .reset            (reset),
        .overload_jal     (overload_jal),
        .ret_handler_addr (ret_handler_addr),
        .in_valid         (alu_commit_valid),
        .in_ready_out     (alu_commit_ready),
        .in_wid           (commit_wid),
        .in_is_jal        (alu_commit_is_jal),
        .in_tmask         (commit_tmask),
        .in_data          (alu_commit_data),
        .out_valid        (commit_valid),
        .out_data         (commit_data),
        .out_ready        (commit_ready),
        .ret_save_valid   (ret_save_valid),
        .ret_save_wid     (ret_save_wid),
        .ret_save_pc      (ret_save_pc),
        .ovl_state        (ovl_state),
        .all_hit          (all_hit)
    );

endmodule

/* dv/execute_tb.sv */
// testbench for the SIMT execute stage
// reads instruction records from the stimulus file and checks commits in order
`timescale 1ns/100ps

module execute_tb import exec_isa_pkg::*; import exec_itr_pkg::*;;

    localparam int WARP_CNT   = 4;
    localparam int THREAD_CNT = 4;
    localparam int WID_W      = 2;
    localparam int DW         = THREAD_CNT * XLEN;
    localparam logic [XLEN-1:0] HANDLER = 32'h0000_8000;
    localparam int TIMEOUT    = 60;

    typedef struct packed {
        logic [WID_W-1:0]      wid;
        logic [THREAD_CNT-1:0] tmask;
        logic [XLEN-1:0]       pc;
        logic [RD_W-1:0]       rd;
        logic                  wb;
        logic [XLEN-1:0]       data;
        logic                  br;
        logic                  taken;
        logic [XLEN-1:0]       dest;
        logic                  save;
        logic [1:0]            state;
        logic                  bp;
        int                    cyc;
    } exp_t;

    logic clk;
    logic reset;
    logic dispatch_valid;
    logic dispatch_ready;
    logic [WID_W-1:0] dispatch_wid;
    logic [THREAD_CNT-1:0] dispatch_tmask;
    logic [XLEN-1:0] dispatch_pc;
    alu_op_t dispatch_op;
    logic [RD_W-1:0] dispatch_rd;
    logic dispatch_wb;
    logic [DW-1:0] dispatch_rs1_data;
    logic [DW-1:0] dispatch_rs2_data;
    logic [XLEN-1:0] dispatch_imm;
    logic commit_valid;
    logic commit_ready;
    logic [WID_W-1:0] commit_wid;
    logic [THREAD_CNT-1:0] commit_tmask;
    logic [XLEN-1:0] commit_pc;
    logic [RD_W-1:0] commit_rd;
    logic commit_wb;
    logic [DW-1:0] commit_data;
    logic branch_valid;
    logic [WID_W-1:0] branch_wid;
    logic branch_taken;
    logic [XLEN-1:0] branch_dest;
    logic overload_jal;
    logic [XLEN-1:0] ret_handler_addr;
    logic ret_save_valid;
    logic [WID_W-1:0] ret_save_wid;
    logic [XLEN-1:0] ret_save_pc;
    ovl_state_t ovl_state;
    logic all_hit;
    logic sim_ebreak;

    exp_t expected_q[$];
    int   cycle;
    int   seed;
    logic bp_on;

    execute_stage #(
        .WARP_CNT   (WARP_CNT),
        .THREAD_CNT (THREAD_CNT),
        .WID_W      (WID_W)
    ) i_dut (
        .clk (clk), .reset (reset),
        .dispatch_valid (dispatch_valid), .dispatch_ready (dispatch_ready),
        .dispatch_wid (dispatch_wid), .dispatch_tmask (dispatch_tmask),
        .dispatch_pc (dispatch_pc), .dispatch_op (dispatch_op),
        .dispatch_rd (dispatch_rd), .dispatch_wb (dispatch_wb),
        .dispatch_rs1_data (dispatch_rs1_data), .dispatch_rs2_data (dispatch_rs2_data),
        .dispatch_imm (dispatch_imm),
        .commit_valid (commit_valid), .commit_ready (commit_ready),
        .commit_wid (commit_wid), .commit_tmask (commit_tmask),
        .commit_pc (commit_pc), .commit_rd (commit_rd),
        .commit_wb (commit_wb), .commit_data (commit_data),
        .branch_valid (branch_valid), .branch_wid (branch_wid),
        .branch_taken (branch_taken), .branch_dest (branch_dest),
        .overload_jal (overload_jal), .ret_handler_addr (ret_handler_addr),
        .ret_save_valid (ret_save_valid), .ret_save_wid (ret_save_wid),
        .ret_save_pc (ret_save_pc), .ovl_state (ovl_state),
        .all_hit (all_hit), .sim_ebreak (sim_ebreak)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic check_value(input string what, input logic [DW-1:0] got,
                               input logic [DW-1:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    task automatic stop_with(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    // inactive lanes must read zero
    function automatic logic [DW-1:0] lanes_of(input logic [THREAD_CNT-1:0] mask,
                                               input logic [XLEN-1:0] word);
        logic [DW-1:0] res;
        res = '0;
        for (int i = 0; i < THREAD_CNT; i++) begin
            if (mask[i]) begin
                res[i*XLEN +: XLEN] = word;
            end
        end
        return res;
    endfunction

    task automatic drain_pipeline();
        int tries;
        tries = 0;
        dispatch_valid = 1'b0;
        while (expected_q.size() != 0) begin
            @(posedge clk);
            #20;
            tries++;
            if (tries > TIMEOUT) begin
                stop_with("pipeline did not drain in time");
            end
        end
    endtask

    // the back-pressure source holds commit_ready high while bp_on is low
    always @(posedge clk) begin
        #10;
        if (bp_on) begin
            commit_ready = $random(seed);
        end else begin
            commit_ready = 1'b1;
        end
    end

    // the commit monitor samples at the falling edge where everything is stable
    initial begin
        exp_t e;
        logic          holding;
        logic [DW-1:0] held_data;
        logic [XLEN-1:0] held_pc;
        logic          state_due;
        logic [1:0]    state_exp;
        holding = 1'b0;
        state_due = 1'b0;
        state_exp = '0;
        forever begin
            @(negedge clk);
            if (!reset) begin
                if (state_due) begin
                    check_value("ovl_state", ovl_state, state_exp);
                    check_value("all_hit", all_hit, state_exp == 2'd2);
                    state_due = 1'b0;
                end
                check_value("dispatch_ready", dispatch_ready,
                            !(expected_q.size() == 2 && !commit_ready));
                if (holding && !commit_valid) begin
                    stop_with("a waiting commit disappeared before it was taken");
                end
                if (commit_valid && expected_q.size() == 0) begin
                    stop_with("commit appeared with no instruction outstanding");
                end
                if (commit_valid && holding) begin
                    check_value("held commit_pc", commit_pc, held_pc);
                    check_value("held commit_data", commit_data, held_data);
                end
                if (commit_valid && commit_ready) begin
                    e = expected_q.pop_front();
                    check_value("commit_wid", commit_wid, e.wid);
                    check_value("commit_tmask", commit_tmask, e.tmask);
                    check_value("commit_pc", commit_pc, e.pc);
                    check_value("commit_rd", commit_rd, e.rd);
                    check_value("commit_wb", commit_wb, e.wb);
                    check_value("commit_data", commit_data, lanes_of(e.tmask, e.data));
                    check_value("branch_valid", branch_valid, e.br);
                    if (e.br) begin
                        check_value("branch_wid", branch_wid, e.wid);
                        check_value("branch_taken", branch_taken, e.taken);
                        check_value("branch_dest", branch_dest, e.dest);
                    end
                    check_value("ret_save_valid", ret_save_valid, e.save);
                    if (e.save) begin
                        check_value("ret_save_wid", ret_save_wid, e.wid);
                        check_value("ret_save_pc", ret_save_pc, e.pc + 32'd4);
                    end
                    if (!e.bp) begin
                        check_value("commit latency", cycle - e.cyc, 2);
                    end
                    holding = 1'b0;
                    state_due = 1'b1;
                    state_exp = e.state;
                end else begin
                    check_value("branch_valid while idle", branch_valid, 1'b0);
                    check_value("ret_save_valid while idle", ret_save_valid, 1'b0);
                    holding = commit_valid;
                    held_pc = commit_pc;
                    held_data = commit_data;
                end
            end
        end
    end

    // driver
    initial begin
        int fd;
        int n;
        int idx;
        int tries;
        logic done;
        string line;
        exp_t e;
        logic [31:0] f_bp, f_ovl, f_wid, f_mask, f_pc, f_op, f_rs1, f_rs2, f_imm;
        logic [31:0] f_data, f_br, f_taken, f_save, f_state;
        seed = 32'h1099_4ac1;
        cycle = 0;
        bp_on = 1'b0;
        reset = 1'b1;
        commit_ready = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_wid = '0;
        dispatch_tmask = '0;
        dispatch_pc = '0;
        dispatch_op = OP_ADD;
        dispatch_rd = '0;
        dispatch_wb = 1'b0;
        dispatch_rs1_data = '0;
        dispatch_rs2_data = '0;
        dispatch_imm = '0;
        overload_jal = 1'b0;
        ret_handler_addr = HANDLER;
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_value("reset commit_valid", commit_valid, 1'b0);
        check_value("reset branch_valid", branch_valid, 1'b0);
        check_value("reset ret_save_valid", ret_save_valid, 1'b0);
        check_value("reset sim_ebreak", sim_ebreak, 1'b0);
        check_value("reset all_hit", all_hit, 1'b0);
        check_value("reset ovl_state", ovl_state, OVL_OFF);
        @(posedge clk);
        #10 reset = 1'b0;
        // the monitor flags any commit that shows up during these idle cycles
        repeat (3) @(posedge clk);
        #10;
        fd = $fopen("dv/execute_stimulus.txt", "r");
        if (fd == 0) begin
            stop_with("cannot open dv/execute_stimulus.txt");
        end
        idx = 0;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 4 || line.substr(0, 0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f_bp, f_ovl, f_wid, f_mask, f_pc, f_op, f_rs1, f_rs2, f_imm,
                        f_data, f_br, f_taken, f_save, f_state);
            if (n != 14) begin
                stop_with("malformed record in the stimulus file");
            end
            // mode changes only happen on an empty pipeline
            if (f_bp[0] != bp_on || f_ovl[0] != overload_jal) begin
                drain_pipeline();
                bp_on = f_bp[0];
                overload_jal = f_ovl[0];
                repeat (2) @(posedge clk);
                #10;
            end
            dispatch_valid = 1'b1;
            dispatch_wid = f_wid[WID_W-1:0];
            dispatch_tmask = f_mask[THREAD_CNT-1:0];
            dispatch_pc = f_pc;
            dispatch_op = alu_op_t'(f_op[3:0]);
            dispatch_rd = idx[RD_W-1:0];
            dispatch_wb = !idx[0];
            dispatch_rs1_data = {THREAD_CNT{f_rs1}};
            dispatch_rs2_data = {THREAD_CNT{f_rs2}};
            dispatch_imm = f_imm;
            done = 1'b0;
            tries = 0;
            while (!done) begin
                @(negedge clk);
                if (dispatch_ready) begin
                    check_value("sim_ebreak", sim_ebreak,
                                f_op[3:0] == 4'd11 && f_wid == 0);
                    e.cyc = cycle;
                    done = 1'b1;
                end else begin
                    check_value("sim_ebreak while stalled", sim_ebreak, 1'b0);
                    tries++;
                    if (tries > TIMEOUT) begin
                        stop_with("dispatch_ready stayed low too long");
                    end
                end
            end
            @(posedge clk);
            #10;
            e.wid = f_wid[WID_W-1:0];
            e.tmask = f_mask[THREAD_CNT-1:0];
            e.pc = f_pc;
            e.rd = idx[RD_W-1:0];
            e.wb = !idx[0];
            e.data = f_data;
            e.br = f_br[0];
            e.taken = f_taken[0];
            e.dest = f_pc + f_imm;
            e.save = f_save[0];
            e.state = f_state[1:0];
            e.bp = bp_on;
            expected_q.push_back(e);
            dispatch_valid = 1'b0;
            idx++;
        end
        $fclose(fd);
        drain_pipeline();
        repeat (3) @(posedge clk);
        if (idx == 0) begin
            stop_with("no records were read from the stimulus file");
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

/* compile.f */
src/exec_isa_pkg.sv
src/exec_itr_pkg.sv
src/alu_unit.sv
src/jal_overload.sv
src/execute_stage.sv
dv/execute_tb.sv

/* dv/execute_stimulus.txt */
# bp ovl wid tmask pc op rs1 rs2 imm | expected: data br taken save state
# hex fields; data is the value on every active lane, state is ovl_state after commit
0 0 1 f 00000100 0 00000005 00000003 00000000 00000008 0 0 0 0
0 0 2 5 00000104 1 00000005 00000007 00000000 fffffffe 0 0 0 0
0 0 3 a 00000108 2 0000ff0f 000f0ff0 00000000 00000f00 0 0 0 0
0 0 0 3 0000010c 3 0000ff00 000000ff 00000000 0000ffff 0 0 0 0
0 0 1 c 00000110 4 ffff0000 0f0f0f0f 00000000 f0f00f0f 0 0 0 0
0 0 2 9 00000114 5 00000003 00000024 00000000 00000030 0 0 0 0
0 0 3 6 00000118 6 80000000 0000001f 00000000 00000001 0 0 0 0
0 0 0 f 0000011c 7 ffffffff 00000001 00000000 00000001 0 0 0 0
0 0 1 1 00000120 7 00000005 fffffffe 00000000 00000000 0 0 0 0
# branches, JAL and EBREAK/ECALL
0 0 2 f 00000200 8 00000011 00000011 00000040 00000000 1 1 0 0
0 0 3 f 00000210 9 00000011 00000011 fffffff0 00000000 1 0 0 0
0 0 0 f 00000220 9 00000001 00000002 00000008 00000000 1 1 0 0
0 0 1 7 00000300 a 00000000 00000000 00000020 00000304 1 1 0 0
0 0 0 f 00000310 b 00000000 00000000 00000000 00000000 0 0 0 0
0 0 2 f 00000314 b 00000000 00000000 00000000 00000000 0 0 0 0
# random back-pressure on commit_ready
1 0 0 f 00000400 0 00000001 00000001 00000000 00000002 0 0 0 0
1 0 1 f 00000404 0 00000010 00000020 00000000 00000030 0 0 0 0
1 0 2 3 00000408 1 00000100 00000001 00000000 000000ff 0 0 0 0
1 0 3 f 0000040c 4 aaaaaaaa 55555555 00000000 ffffffff 0 0 0 0
1 0 0 f 00000410 6 0000ff00 00000008 00000000 000000ff 0 0 0 0
1 0 1 f 00000414 8 00000003 00000004 00000010 00000000 1 0 0 0
1 0 2 f 00000500 a 00000000 00000000 00000100 00000504 1 1 0 0
1 0 3 f 00000504 2 12345678 0000ffff 00000000 00005678 0 0 0 0
# JAL overload armed
1 1 0 f 00000600 a 00000000 00000000 00000010 00008000 1 1 1 1
1 1 0 f 00000610 a 00000000 00000000 00000010 00000614 1 1 0 1
1 1 1 f 00000618 0 00000002 00000002 00000000 00000004 0 0 0 1
1 1 1 5 00000620 a 00000000 00000000 00000010 00008000 1 1 1 1
1 1 2 3 00000630 a 00000000 00000000 00000010 00008000 1 1 1 1
1 1 3 f 00000640 a 00000000 00000000 00000010 00008000 1 1 1 2
1 1 1 f 00000650 a 00000000 00000000 00000010 00000654 1 1 0 2
# overload dropped
0 0 0 f 00000700 a 00000000 00000000 00000010 00000704 1 1 0 0
0 0 0 f 00000704 b 00000000 00000000 00000000 00000000 0 0 0 0
